// File: rtl/anc_cfg.svh
`ifndef ANC_CFG_SVH
`define ANC_CFG_SVH

// reference taps and weights per channel
`define ANC_NTAPS     8

// must hold ANC_NTAPS-1
`define ANC_TAP_W     3

// primary, reference and output sample width
`define ANC_DATA_W    14

// weight word, wraps on update
`define ANC_WEIGHT_W  16

// weights are Q(16-12).12
`define ANC_FRAC      12

// step size mu = 2^-15 applied to e * x
`define ANC_MU_SHIFT  15

`endif

// File: rtl/anc_pkg.sv
`include "anc_cfg.svh"

package anc_pkg;

    // signed sample on the reference, primary and error paths
    typedef logic signed [`ANC_DATA_W-1:0] sample_t;

    // signed filter weight
    typedef logic signed [`ANC_WEIGHT_W-1:0] weight_t;

    // product width plus growth for ANC_NTAPS terms, plus a guard bit
    typedef logic signed [`ANC_DATA_W+`ANC_WEIGHT_W+`ANC_TAP_W:0] acc_t;

    typedef logic [`ANC_TAP_W-1:0] tap_idx_t;

    // one-hot sequencer codes, ST_NONE is the all-zero code left after an upset
    typedef enum logic [4:0] {
        ST_NONE   = 5'b00000,
        ST_IDLE   = 5'b00001,
        ST_FILTER = 5'b00010,
        ST_ERROR  = 5'b00100,
        ST_UPDATE = 5'b01000,
        ST_DONE   = 5'b10000
    } seq_state_t;

    // frame control fanned out to the delay line and both channels
    typedef struct packed {
        logic     start;      // frame accepted this cycle
        logic     filter_en;  // mac step on tap
        logic     error_en;   // error register loads at end of cycle
        logic     update_en;  // weight[tap] update
        tap_idx_t tap;
    } frame_ctl_t;

endpackage

// File: rtl/frame_sequencer.sv
module frame_sequencer (
    input  logic                clk,
    input  logic                rstn,
    input  logic                head_flag,
    input  logic                last_tap,
    input  anc_pkg::tap_idx_t   tap,
    output anc_pkg::frame_ctl_t ctl,
    output logic                count_en,
    output logic                count_clr
);
    import anc_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
                if (head_flag)
                    state_nxt = ST_FILTER;
            ST_FILTER:
                if (last_tap)
                    state_nxt = ST_ERROR;
            ST_ERROR:
                state_nxt = ST_UPDATE;              // single cycle
            ST_UPDATE:
                if (last_tap)
                    state_nxt = ST_DONE;
            ST_DONE:
                if (!head_flag)
                    state_nxt = ST_IDLE;            // wait for head_flag to drop
            ST_NONE:
                state_nxt = ST_IDLE;
            default:
                state_nxt = ST_IDLE;                // multi-hot codes
        endcase
    end

    // head_flag only counts in idle, so a long level gives one frame
    always_comb
    begin
        ctl.start     = (state == ST_IDLE) && head_flag;
        ctl.filter_en = (state == ST_FILTER);
        ctl.error_en  = (state == ST_ERROR);
        ctl.update_en = (state == ST_UPDATE);
        ctl.tap       = tap;
    end

    assign count_en  = ctl.filter_en | ctl.update_en;

    // restart the index for the filter run and again for the update run
    assign count_clr = ctl.start | ctl.error_en;

endmodule

// File: rtl/step_counter.sv
`include "anc_cfg.svh"

module step_counter (
    input  logic              clk,
    input  logic              rstn,
    input  logic              count_en,
    input  logic              count_clr,
    output anc_pkg::tap_idx_t tap,
    output logic              last_tap
);
    import anc_pkg::*;

    localparam tap_idx_t LAST_IDX = tap_idx_t'(`ANC_NTAPS - 1);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            tap <= '0;
        end
        else if (count_clr)
        begin
            tap <= '0;                             // clear wins over enable
        end
        else if (count_en)
        begin
            tap <= tap_idx_t'(tap + 1'b1);
        end
    end

    assign last_tap = (tap == LAST_IDX);

endmodule

// File: rtl/ref_delay_line.sv
`include "anc_cfg.svh"

module ref_delay_line (
    input  logic                clk,
    input  logic                rstn,
    input  anc_pkg::frame_ctl_t ctl,
    input  anc_pkg::sample_t    reff,
    output anc_pkg::sample_t    tap_out
);
    import anc_pkg::*;

    sample_t taps [`ANC_NTAPS];

    // one shift per frame, newest sample at tap 0
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < `ANC_NTAPS; i++)
            begin
                taps[i] <= '0;
            end
        end
        else if (ctl.start)
        begin
            taps[0] <= reff;
            for (int i = 1; i < `ANC_NTAPS; i++)
            begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // shared read port, both channels walk the taps in step
    assign tap_out = taps[ctl.tap];

endmodule

// File: rtl/lms_channel.sv
`include "anc_cfg.svh"

module lms_channel (
    input  logic                clk,
    input  logic                rstn,
    input  anc_pkg::frame_ctl_t ctl,
    input  anc_pkg::sample_t    primary,
    input  anc_pkg::sample_t    ref_tap,
    output anc_pkg::sample_t    err
);
    import anc_pkg::*;

    localparam int Y_W = $bits(acc_t) - `ANC_FRAC;

    localparam sample_t SAT_MAX = {1'b0, {(`ANC_DATA_W-1){1'b1}}};
    localparam sample_t SAT_MIN = {1'b1, {(`ANC_DATA_W-1){1'b0}}};

    weight_t weight [`ANC_NTAPS];
    acc_t    acc;

    weight_t w_sel;
    weight_t w_step;
    sample_t err_sat;

    logic signed [`ANC_WEIGHT_W+`ANC_DATA_W-1:0] mac_prod;
    logic signed [2*`ANC_DATA_W-1:0]             upd_prod;
    logic signed [Y_W-1:0]                       y;
    logic signed [Y_W:0]                         diff;

    assign w_sel    = weight[ctl.tap];
    assign mac_prod = w_sel * ref_tap;

    // y = sum(w * x) back to sample scale
    assign y    = acc[$bits(acc_t)-1:`ANC_FRAC];
    assign diff = primary - y;

    always_comb
    begin
        if (diff > SAT_MAX)
        begin
            err_sat = SAT_MAX;
        end
        else if (diff < SAT_MIN)
        begin
            err_sat = SAT_MIN;
        end
        else
        begin
            err_sat = diff[`ANC_DATA_W-1:0];
        end
    end

    // mu * e * x, the error register is stable through the whole update run
    assign upd_prod = err * ref_tap;
    assign w_step   = weight_t'(upd_prod >>> `ANC_MU_SHIFT);

    always_ff @(posedge clk)
    begin
        if (ctl.start)
        begin
            acc <= '0;
        end
        else if (ctl.filter_en)
        begin
            acc <= acc + mac_prod;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            err <= '0;
        end
        else if (ctl.error_en)
        begin
            err <= err_sat;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < `ANC_NTAPS; i++)
            begin
                weight[i] <= '0;
            end
        end
        else if (ctl.update_en)
        begin
            weight[ctl.tap] <= w_sel + w_step;   // wraps in 16 bits
        end
    end

endmodule

// File: rtl/anc_top.sv
module anc_top (
    input  logic             clk,
    input  logic             rstn,
    input  logic             head_flag,
    input  anc_pkg::sample_t reff,
    input  anc_pkg::sample_t primary_a,
    input  anc_pkg::sample_t primary_b,
    output anc_pkg::sample_t dout,
    output logic             frame_done
);
    import anc_pkg::*;

    frame_ctl_t ctl;
    tap_idx_t   tap;
    logic       last_tap;
    logic       count_en;
    logic       count_clr;
    logic       out_load;

    sample_t ref_tap;
    sample_t prim_a_q;
    sample_t prim_b_q;
    sample_t err_a;
    sample_t err_b;

    frame_sequencer seq_i (
        .clk       (clk),
        .rstn      (rstn),
        .head_flag (head_flag),
        .last_tap  (last_tap),
        .tap       (tap),
        .ctl       (ctl),
        .count_en  (count_en),
        .count_clr (count_clr)
    );

    step_counter step_i (
        .clk       (clk),
        .rstn      (rstn),
        .count_en  (count_en),
        .count_clr (count_clr),
        .tap       (tap),
        .last_tap  (last_tap)
    );

    ref_delay_line ref_i (
        .clk     (clk),
        .rstn    (rstn),
        .ctl     (ctl),
        .reff    (reff),
        .tap_out (ref_tap)
    );

    lms_channel chan_a (
        .clk     (clk),
        .rstn    (rstn),
        .ctl     (ctl),
        .primary (prim_a_q),
        .ref_tap (ref_tap),
        .err     (err_a)
    );

    lms_channel chan_b (
        .clk     (clk),
        .rstn    (rstn),
        .ctl     (ctl),
        .primary (prim_b_q),
        .ref_tap (ref_tap),
        .err     (err_b)
    );

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            prim_a_q <= '0;
            prim_b_q <= '0;
        end
        else if (ctl.start)
        begin
            prim_a_q <= primary_a;
            prim_b_q <= primary_b;
        end
    end

    // first update cycle, both error registers loaded on the edge before
    assign out_load = ctl.update_en && (ctl.tap == '0);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            dout       <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= out_load;
            if (out_load)
            begin
                dout <= err_a + err_b;             // 14-bit wrap
            end
        end
    end

endmodule

// File: testbench/anc_checker.sv
module anc_checker (
    input  logic             clk,
    input  logic             rstn,
    input  logic             frame_done,
    input  anc_pkg::sample_t dout,
    input  logic             exp_push,
    input  anc_pkg::sample_t exp_data,
    output int               err_count,
    output int               check_count,
    output int               done_count
);
    timeunit 1ns;
    timeprecision 1ps;

    import anc_pkg::*;

    sample_t exp_q [$];
    sample_t exp_val;
    logic    done_q;                                // frame_done on the previous falling edge

    initial
    begin
        err_count   = 0;
        check_count = 0;
        done_count  = 0;
        done_q      = 1'b0;
    end

    always @(posedge clk)
    begin
        if (!rstn)
        begin
            exp_q.delete();                         // an aborted frame never reaches dout
        end
        else if (exp_push)
        begin
            exp_q.push_back(exp_data);
        end
    end

    // outputs are registered on the rising edge, so read them on the falling one
    always @(negedge clk)
    begin
        if (frame_done && done_q)
        begin
            $display("frame_done stayed high for more than one cycle at %0t", $time);
            err_count++;
        end
        else if (frame_done)
        begin
            done_count++;
            if (exp_q.size() == 0)
            begin
                $display("frame_done at %0t with no frame pending", $time);
                err_count++;
            end
            else
            begin
                exp_val = exp_q.pop_front();
                check_count++;
                if (dout !== exp_val)
                begin
                    $display("Mismatch %0t: dout expected %0d got %0d", $time, exp_val, dout);
                    err_count++;
                end
            end
        end
        done_q = frame_done;
    end

endmodule

// File: testbench/anc_tb.sv
`include "anc_cfg.svh"

module anc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import anc_pkg::*;

    localparam int     NT       = `ANC_NTAPS;
    localparam int     N_FRAMES = 1 + 150 + 100 + 20 + 12 + 2;
    localparam int     TIMEOUT  = 16 + N_FRAMES * 30 + 200;
    localparam longint S_MAX    = (1 << (`ANC_DATA_W - 1)) - 1;
    localparam longint S_MIN    = -(1 << (`ANC_DATA_W - 1));

    logic    clk;
    logic    rstn;
    logic    head_flag;
    sample_t reff;
    sample_t primary_a;
    sample_t primary_b;
    sample_t dout;
    logic    frame_done;

    logic    exp_push;
    sample_t exp_data;
    int      chk_errors;
    int      chk_count;
    int      done_count;

    integer  seed;
    int      cycles = 0;
    int      tb_errors;
    int      tests;
    int      sat_hits;
    longint  last_eb;

    longint  ref_m [NT];                            // model delay line, newest at 0
    longint  w_m   [2][NT];                         // model weights, channel a then b

    anc_top anc_top_i (
        .clk        (clk),
        .rstn       (rstn),
        .head_flag  (head_flag),
        .reff       (reff),
        .primary_a  (primary_a),
        .primary_b  (primary_b),
        .dout       (dout),
        .frame_done (frame_done)
    );

    anc_checker check_i (
        .clk         (clk),
        .rstn        (rstn),
        .frame_done  (frame_done),
        .dout        (dout),
        .exp_push    (exp_push),
        .exp_data    (exp_data),
        .err_count   (chk_errors),
        .check_count (chk_count),
        .done_count  (done_count)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic longint wrap_weight(input longint v);
        logic signed [`ANC_WEIGHT_W-1:0] t;
        t = v[`ANC_WEIGHT_W-1:0];
        return t;
    endfunction

    function automatic longint wrap_sample(input longint v);
        logic signed [`ANC_DATA_W-1:0] t;
        t = v[`ANC_DATA_W-1:0];
        return t;
    endfunction

    // uniform value in the signed range of the given width
    function automatic sample_t rand_sample(input int bits);
        int v;
        v = $random(seed);
        return sample_t'(v >>> (32 - bits));
    endfunction

    task automatic model_reset();
        for (int k = 0; k < NT; k++)
        begin
            ref_m[k]   = 0;
            w_m[0][k] = 0;
            w_m[1][k] = 0;
        end
    endtask

    task automatic model_channel(input int ch, input longint prim, output longint e);
        longint acc;
        longint d;
        acc = 0;
        for (int k = 0; k < NT; k++)
        begin
            acc += w_m[ch][k] * ref_m[k];
        end
        d = prim - (acc >>> `ANC_FRAC);
        if (d > S_MAX || d < S_MIN)
        begin
            sat_hits++;
        end
        e = (d > S_MAX) ? S_MAX : ((d < S_MIN) ? S_MIN : d);
        for (int k = 0; k < NT; k++)
        begin
            w_m[ch][k] = wrap_weight(w_m[ch][k] + ((e * ref_m[k]) >>> `ANC_MU_SHIFT));
        end
    endtask

    task automatic model_frame(input sample_t r, input sample_t pa, input sample_t pb,
                               output sample_t exp);
        longint ea;
        longint eb;
        for (int k = NT - 1; k > 0; k--)
        begin
            ref_m[k] = ref_m[k-1];
        end
        ref_m[0] = r;
        model_channel(0, pa, ea);
        model_channel(1, pb, eb);
        last_eb = eb;
        exp = wrap_sample(ea + eb);
    endtask

    // launch one frame, hold head_flag for hold extra cycles, wait until idle again
    task automatic run_frame(input sample_t r, input sample_t pa, input sample_t pb,
                             input int hold, output sample_t got);
        sample_t exp;
        int      cyc;
        int      done_cyc;
        int      drop_cyc;
        logic    seen;
        @(negedge clk);
        model_frame(r, pa, pb, exp);
        reff      = r;
        primary_a = pa;
        primary_b = pb;
        head_flag = 1'b1;
        exp_data  = exp;
        exp_push  = 1'b1;
        cyc      = 0;
        done_cyc = 0;
        drop_cyc = 0;
        seen     = 1'b0;
        got      = '0;
        while (!seen || head_flag || cyc < done_cyc + 10 || cyc < drop_cyc + 2)
        begin
            @(negedge clk);
            cyc++;
            exp_push = 1'b0;
            if (cyc == 1)
            begin
                reff      = rand_sample(14);            // inputs only count at the start edge
                primary_a = rand_sample(14);
                primary_b = rand_sample(14);
            end
            if (head_flag && cyc > hold)
            begin
                head_flag = 1'b0;
                drop_cyc  = cyc;
            end
            if (frame_done && !seen)
            begin
                seen     = 1'b1;
                done_cyc = cyc;
                got      = dout;
            end
        end
    endtask

    task automatic check_sum(input sample_t pa, input sample_t pb, input sample_t got);
        sample_t exp;
        exp = wrap_sample(longint'(pa) + longint'(pb));
        if (got !== exp)
        begin
            $display("Mismatch %0t: raw primary sum expected %0d got %0d", $time, exp, got);
            tb_errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = tb_errors + chk_errors - errs_before;
        tests++;
        $display("test %0d %s: %s, %0d errors", tests, name, (errs == 0) ? "ok" : "bad", errs);
    endtask

    initial
    begin
        sample_t r;
        sample_t pa;
        sample_t pb;
        sample_t got;
        sample_t prev_r;
        longint  first_mag;
        longint  last_mag;
        longint  ea;
        int      base;
        int      done_base;
        int      hold;

        rstn      = 1'b0;
        head_flag = 1'b0;
        reff      = '0;
        primary_a = '0;
        primary_b = '0;
        exp_push  = 1'b0;
        exp_data  = '0;
        seed      = 32'h218e6b6e;
        tb_errors = 0;
        tests     = 0;
        sat_hits  = 0;
        last_eb   = 0;
        model_reset();
        repeat (16) @(negedge clk);
        rstn = 1'b1;

        base = tb_errors + chk_errors;
        repeat (20)
        begin
            @(negedge clk);
            if (frame_done !== 1'b0 || dout !== '0)
            begin
                $display("Mismatch %0t: after reset dout %0d frame_done %b", $time, dout,
                         frame_done);
                tb_errors++;
            end
        end
        pa = rand_sample(14);
        pb = rand_sample(14);
        run_frame(rand_sample(14), pa, pb, 0, got);
        check_sum(pa, pb, got);
        report_test("reset state", base);

        base = tb_errors + chk_errors;
        repeat (150)
        begin
            run_frame(rand_sample(10), rand_sample(10), rand_sample(10), 0, got);
        end
        report_test("random frames", base);

        // channel a hears the previous reference sample at half scale
        base      = tb_errors + chk_errors;
        first_mag = 0;
        last_mag  = 0;
        prev_r    = '0;
        for (int i = 0; i < 100; i++)
        begin
            r = rand_sample(13);
            run_frame(r, prev_r >>> 1, rand_sample(10), 0, got);
            ea = wrap_sample(longint'(got) - last_eb);      // channel a error as seen at dout
            if (i < 20)
            begin
                first_mag += (ea < 0) ? -ea : ea;
            end
            if (i >= 80)
            begin
                last_mag += (ea < 0) ? -ea : ea;
            end
            prev_r = r;
        end
        if (last_mag >= first_mag)
        begin
            $display("channel a error did not fall: first 20 frames %0d, last 20 frames %0d",
                     first_mag, last_mag);
            tb_errors++;
        end
        report_test("correlated noise", base);

        base     = tb_errors + chk_errors;
        sat_hits = 0;
        repeat (20)
        begin
            r  = ($random(seed) & 1) ? S_MAX : S_MIN;
            pa = ($random(seed) & 1) ? S_MAX : S_MIN;
            pb = ($random(seed) & 1) ? S_MAX : S_MIN;
            run_frame(r, pa, pb, 0, got);
        end
        if (sat_hits == 0)
        begin
            $display("full-scale frames never pushed an error out of range");
            tb_errors++;
        end
        report_test("saturation", base);

        base      = tb_errors + chk_errors;
        done_base = done_count;
        for (int i = 0; i < 12; i++)
        begin
            hold = $random(seed) & 15;
            if (i % 3 == 2)
            begin
                hold += 40;                             // well past the end of the frame
            end
            run_frame(rand_sample(10), rand_sample(10), rand_sample(10), hold, got);
        end
        if (done_count - done_base != 12)
        begin
            $display("frame_done pulsed %0d times for 12 head_flag assertions",
                     done_count - done_base);
            tb_errors++;
        end
        report_test("one frame per head_flag", base);

        base = tb_errors + chk_errors;
        @(negedge clk);
        reff      = rand_sample(14);
        primary_a = rand_sample(14);
        primary_b = rand_sample(14);
        head_flag = 1'b1;
        @(negedge clk);
        head_flag = 1'b0;
        repeat (4) @(negedge clk);
        rstn = 1'b0;                                    // inside the filter run
        model_reset();
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        pa = rand_sample(14);
        pb = rand_sample(14);
        run_frame(rand_sample(14), pa, pb, 0, got);
        check_sum(pa, pb, got);
        report_test("reset mid-frame", base);

        $display("%0d tests, %0d dout checks, %0d errors", tests, chk_count,
                 tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: anc.f
+incdir+rtl
rtl/anc_pkg.sv
rtl/frame_sequencer.sv
rtl/step_counter.sv
rtl/ref_delay_line.sv
rtl/lms_channel.sv
rtl/anc_top.sv
testbench/anc_checker.sv
testbench/anc_tb.sv
